// File: Bender.yml
package:
  name: attention_head

sources:
  - hw/attn_pkg.sv
  - hw/operand_buffer.sv
  - hw/score_unit.sv
  - hw/weighted_sum_unit.sv
  - hw/attention_head.sv
  - target: simulation
    files:
      - sim/tb_attention_head.sv

// File: hw/attention_head.sv
`timescale 1ns/1ns
`default_nettype none

module attention_head
  import attn_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,

  input  in_row_t  query,
  input  logic     query_valid,
  output logic     query_ready,

  input  in_row_t  key,
  input  logic     key_valid,
  output logic     key_ready,

  input  in_row_t  value,
  input  logic     value_valid,
  output logic     value_ready,

  input  in_elem_t pos_bias [SEQ_LEN],
  input  logic     pos_bias_valid,
  output logic     pos_bias_ready,

  output out_row_t out,
  output logic     out_valid,
  input  logic     out_ready
);

  logic       key_full;
  in_row_t    key_rows [SEQ_LEN];
  logic       value_full;
  row_idx_t   value_rd_idx;
  in_row_t    value_rd_row;
  score_row_t score;
  logic       score_valid;
  logic       score_ready;
  logic       head_done;

  // Keys are read as a whole matrix, so the row port stays open
  operand_buffer key_buf_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_row    (key),
    .wr_valid  (key_valid),
    .wr_ready  (key_ready),
    .full      (key_full),
    .head_done (head_done),
    .rd_idx    ('0),
    .rd_row    (),
    .rd_all    (key_rows)
  );

  operand_buffer value_buf_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_row    (value),
    .wr_valid  (value_valid),
    .wr_ready  (value_ready),
    .full      (value_full),
    .head_done (head_done),
    .rd_idx    (value_rd_idx),
    .rd_row    (value_rd_row),
    .rd_all    ()
  );

  score_unit score_unit_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .query          (query),
    .query_valid    (query_valid),
    .query_ready    (query_ready),
    .pos_bias       (pos_bias),
    .pos_bias_valid (pos_bias_valid),
    .pos_bias_ready (pos_bias_ready),
    .key_full       (key_full),
    .key_rows       (key_rows),
    .score          (score),
    .score_valid    (score_valid),
    .score_ready    (score_ready)
  );

  weighted_sum_unit weighted_sum_unit_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .score        (score),
    .score_valid  (score_valid),
    .score_ready  (score_ready),
    .value_full   (value_full),
    .value_rd_idx (value_rd_idx),
    .value_rd_row (value_rd_row),
    .out          (out),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .head_done    (head_done)
  );

endmodule

`default_nettype wire

// File: hw/attn_pkg.sv
`default_nettype none

package attn_pkg;

  // Head geometry
  localparam int SEQ_LEN  = 4;
  localparam int HEAD_DIM = 4;

  // Fixed-point formats with IN_FRAC fraction bits throughout
  localparam int IN_W    = 8;
  localparam int IN_FRAC = 3;
  localparam int SCORE_W = 12;
  localparam int OUT_W   = 16;

  // Holds any dot product or weighted sum without overflow
  localparam int ACC_W = 24;

  // Saturation bounds
  localparam int SCORE_MAX = 2 ** (SCORE_W - 1) - 1;
  localparam int SCORE_MIN = -(2 ** (SCORE_W - 1));
  localparam int OUT_MAX   = 2 ** (OUT_W - 1) - 1;
  localparam int OUT_MIN   = -(2 ** (OUT_W - 1));

  // Half an output LSB added before the final shift
  localparam int OUT_ROUND = 2 ** (IN_FRAC - 1);

  // Accumulate steps plus the cast step
  localparam int STEP_W = $clog2(SEQ_LEN + 1);

  typedef logic signed [IN_W-1:0] in_elem_t;
  typedef in_elem_t in_row_t [HEAD_DIM];
  typedef logic signed [SCORE_W-1:0] score_row_t [SEQ_LEN];
  typedef logic signed [OUT_W-1:0] out_row_t [HEAD_DIM];
  typedef logic [$clog2(SEQ_LEN)-1:0] row_idx_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCUM,
    HOLD
  } wsum_state_e;

  typedef enum logic {
    FILLING,
    FULL
  } buf_state_e;

endpackage

`default_nettype wire

// File: hw/operand_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module operand_buffer
  import attn_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  in_row_t  wr_row,
  input  logic     wr_valid,
  output logic     wr_ready,
  output logic     full,
  input  logic     head_done,
  input  row_idx_t rd_idx,
  output in_row_t  rd_row,
  output in_row_t  rd_all [SEQ_LEN]
);

  buf_state_e state;
  row_idx_t   wr_idx;
  logic       wr_fire;
  in_row_t    mem [SEQ_LEN];

  assign wr_ready = (state == FILLING);
  assign full     = (state == FULL);
  assign wr_fire  = wr_valid && wr_ready;

  // Fill in arrival order, then hold until the head is finished
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= FILLING;
      wr_idx <= '0;
    end else begin
      case (state)
        FILLING: begin
          if (wr_fire) begin
            if (wr_idx == row_idx_t'(SEQ_LEN - 1)) begin
              state  <= FULL;
              wr_idx <= '0;
            end else begin
              wr_idx <= wr_idx + 1'b1;
            end
          end
        end
        FULL: begin
          if (head_done) begin
            state <= FILLING;
          end
        end
        default: state <= FILLING;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_idx] <= wr_row;
    end
  end

  // Row read for the value path
  assign rd_row = mem[rd_idx];

  // Whole matrix, read column-wise by the score unit
  assign rd_all = mem;

endmodule

`default_nettype wire

// File: hw/score_unit.sv
`timescale 1ns/1ns
`default_nettype none

module score_unit
  import attn_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  in_row_t    query,
  input  logic       query_valid,
  output logic       query_ready,
  input  in_elem_t   pos_bias [SEQ_LEN],
  input  logic       pos_bias_valid,
  output logic       pos_bias_ready,
  input  logic       key_full,
  input  in_row_t    key_rows [SEQ_LEN],
  output score_row_t score,
  output logic       score_valid,
  input  logic       score_ready
);

  logic                    join_ready;
  logic signed [ACC_W-1:0] dot [SEQ_LEN];
  logic signed [ACC_W-1:0] biased [SEQ_LEN];
  score_row_t              score_next;

  function automatic logic signed [SCORE_W-1:0] sat_score(
    input logic signed [ACC_W-1:0] x
  );
    if (x > SCORE_MAX) begin
      return SCORE_W'(SCORE_MAX);
    end else if (x < SCORE_MIN) begin
      return SCORE_W'(SCORE_MIN);
    end
    return x[SCORE_W-1:0];
  endfunction

  // Query and bias transfer together, only with a full key matrix
  // and room in the output stage
  assign join_ready = key_full && query_valid && pos_bias_valid &&
                      (!score_valid || score_ready);

  assign query_ready    = join_ready;
  assign pos_bias_ready = join_ready;

  // Dot product against key row j gives element j of query times key^T
  always_comb begin
    for (int j = 0; j < SEQ_LEN; j++) begin
      dot[j] = '0;
      for (int d = 0; d < HEAD_DIM; d++) begin
        dot[j] = dot[j] + query[d] * key_rows[j][d];
      end
      // Drop the extra fraction bits, truncating toward minus infinity
      biased[j]     = (dot[j] >>> IN_FRAC) + ACC_W'(pos_bias[j]);
      score_next[j] = sat_score(biased[j]);
    end
  end

  // One-deep output stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      score_valid <= 1'b0;
    end else if (join_ready) begin
      score_valid <= 1'b1;
    end else if (score_ready) begin
      score_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (join_ready) begin
      score <= score_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/weighted_sum_unit.sv
`timescale 1ns/1ns
`default_nettype none

module weighted_sum_unit
  import attn_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  score_row_t score,
  input  logic       score_valid,
  output logic       score_ready,
  input  logic       value_full,
  output row_idx_t   value_rd_idx,
  input  in_row_t    value_rd_row,
  output out_row_t   out,
  output logic       out_valid,
  input  logic       out_ready,
  output logic       head_done
);

  wsum_state_e             state;
  logic [STEP_W-1:0]       step;
  logic                    last_step;
  row_idx_t                row_cnt;
  logic                    score_fire;
  logic                    out_fire;
  score_row_t              score_reg;
  logic signed [ACC_W-1:0] acc [HEAD_DIM];
  logic signed [ACC_W-1:0] acc_next [HEAD_DIM];
  logic signed [ACC_W-1:0] rounded [HEAD_DIM];

  function automatic logic signed [OUT_W-1:0] sat_out(
    input logic signed [ACC_W-1:0] x
  );
    if (x > OUT_MAX) begin
      return OUT_W'(OUT_MAX);
    end else if (x < OUT_MIN) begin
      return OUT_W'(OUT_MIN);
    end
    return x[OUT_W-1:0];
  endfunction

  assign score_ready  = (state == IDLE) && value_full;
  assign score_fire   = score_valid && score_ready;
  assign out_valid    = (state == HOLD);
  assign out_fire     = out_valid && out_ready;
  assign last_step    = (step == STEP_W'(SEQ_LEN));
  assign value_rd_idx = row_idx_t'(step);

  // Last row of the head leaving releases both buffers
  assign head_done = out_fire && (row_cnt == row_idx_t'(SEQ_LEN - 1));

  // Steps 0 to SEQ_LEN-1 accumulate, the final step casts
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      step    <= '0;
      row_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (score_fire) begin
            state <= ACCUM;
            step  <= '0;
          end
        end
        ACCUM: begin
          if (last_step) begin
            state <= HOLD;
          end else begin
            step <= step + 1'b1;
          end
        end
        HOLD: begin
          if (out_fire) begin
            state <= IDLE;
            if (head_done) begin
              row_cnt <= '0;
            end else begin
              row_cnt <= row_cnt + 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // score[j] scales value row j
  always_comb begin
    for (int d = 0; d < HEAD_DIM; d++) begin
      acc_next[d] = acc[d] + score_reg[value_rd_idx] * value_rd_row[d];
      // Round half up
      rounded[d]  = (acc[d] + ACC_W'(OUT_ROUND)) >>> IN_FRAC;
    end
  end

  always_ff @(posedge clk) begin
    if (score_fire) begin
      score_reg <= score;
      for (int d = 0; d < HEAD_DIM; d++) begin
        acc[d] <= '0;
      end
    end else if (state == ACCUM) begin
      if (last_step) begin
        for (int d = 0; d < HEAD_DIM; d++) begin
          out[d] <= sat_out(rounded[d]);
        end
      end else begin
        acc <= acc_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/attn_stimulus.txt
// Per head five lines of 16 hex words, row by row with element 0 first:
// query, key, value, pos_bias (8-bit each), then the expected out rows (16-bit)
08 10 00 00 00 00 08 08 f8 08 04 00 02 03 fb 06
08 00 00 00 08 08 00 00 00 00 08 10 00 f8 00 08
08 00 00 04 00 08 00 fc 00 00 08 02 08 08 08 00
00 00 00 00 08 00 00 f8 00 00 00 00 01 ff 02 fe
fff8 0008 fff0 fff8 0008 0000 0018 000a fff0 fff8 fffc fffd 0004 0005 000a 0002
// Saturates both the score and the output stage
7f 7f 7f 7f 80 80 80 80 ff 00 00 00 00 00 00 00
7f 7f 7f 7f 80 80 80 80 00 00 00 00 08 00 00 00
7f 80 00 01 80 7f 00 00 00 00 00 00 00 00 08 00
00 00 05 00 00 00 00 80 7f 7f 7f 7f 80 7f 00 01
7fff 8000 007f 0100 8000 7fff ff00 ff00 fdf2 01ee 007e 000e f020 0fe0 0001 fff0
05 02 07 01 fb fd 00 00 10 10 10 10 00 00 00 f0
04 00 00 00 00 0c 00 00 00 00 f8 00 03 00 00 08
01 02 03 04 ff 00 01 00 02 02 02 02 00 fd 00 05
01 01 01 01 00 00 00 00 fc 00 04 00 0a 14 1e 28
fffe fffe 0000 0002 0000 0000 fffe fffd fffb fff6 0002 000d 0006 0001 000e 001c

// File: sim/tb_attention_head.sv
`timescale 1ns/1ns
`default_nettype none

module tb_attention_head
  import attn_pkg::*;
();

  localparam int NUM_HEADS     = 3;
  localparam int HEAD_WORDS    = 80;
  localparam int NUM_WORDS     = NUM_HEADS * HEAD_WORDS;
  localparam int Q_OFS         = 0;
  localparam int K_OFS         = 16;
  localparam int V_OFS         = 32;
  localparam int B_OFS         = 48;
  localparam int E_OFS         = 64;
  localparam int TIMEOUT_LIMIT =
    NUM_HEADS * (4 * SEQ_LEN + SEQ_LEN * (SEQ_LEN + 2)) * 4 + 100;

  logic     clk;
  logic     arst_n;
  in_row_t  query;
  logic     query_valid;
  logic     query_ready;
  in_row_t  key;
  logic     key_valid;
  logic     key_ready;
  in_row_t  value;
  logic     value_valid;
  logic     value_ready;
  in_elem_t pos_bias [SEQ_LEN];
  logic     pos_bias_valid;
  logic     pos_bias_ready;
  out_row_t out;
  logic     out_valid;
  logic     out_ready;

  logic [15:0] stim_mem [NUM_WORDS];
  int          error_count;
  int          check_count;
  int          cycle_count;

  attention_head attention_head_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .query          (query),
    .query_valid    (query_valid),
    .query_ready    (query_ready),
    .key            (key),
    .key_valid      (key_valid),
    .key_ready      (key_ready),
    .value          (value),
    .value_valid    (value_valid),
    .value_ready    (value_ready),
    .pos_bias       (pos_bias),
    .pos_bias_valid (pos_bias_valid),
    .pos_bias_ready (pos_bias_ready),
    .out            (out),
    .out_valid      (out_valid),
    .out_ready      (out_ready)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic load_key_rows(input int head);
    int base;
    base = head * HEAD_WORDS + K_OFS;
    for (int r = 0; r < SEQ_LEN; r++) begin
      for (int d = 0; d < HEAD_DIM; d++) begin
        key[d] <= stim_mem[base + r * HEAD_DIM + d][IN_W-1:0];
      end
      key_valid <= 1'b1;
      do begin
        @(posedge clk);
      end while (!key_ready);
    end
    key_valid <= 1'b0;
  endtask

  task automatic load_value_rows(input int head);
    int base;
    base = head * HEAD_WORDS + V_OFS;
    for (int r = 0; r < SEQ_LEN; r++) begin
      for (int d = 0; d < HEAD_DIM; d++) begin
        value[d] <= stim_mem[base + r * HEAD_DIM + d][IN_W-1:0];
      end
      value_valid <= 1'b1;
      do begin
        @(posedge clk);
      end while (!value_ready);
    end
    value_valid <= 1'b0;
  endtask

  // Query and bias are offered right away, before the keys are complete
  task automatic offer_query_rows(input int head);
    int base;
    int keys_seen;
    base      = head * HEAD_WORDS;
    keys_seen = 0;
    for (int r = 0; r < SEQ_LEN; r++) begin
      for (int d = 0; d < HEAD_DIM; d++) begin
        query[d] <= stim_mem[base + Q_OFS + r * HEAD_DIM + d][IN_W-1:0];
      end
      for (int j = 0; j < SEQ_LEN; j++) begin
        pos_bias[j] <= stim_mem[base + B_OFS + r * SEQ_LEN + j][IN_W-1:0];
      end
      query_valid    <= 1'b1;
      pos_bias_valid <= 1'b1;
      do begin
        @(posedge clk);
        if (keys_seen < SEQ_LEN) begin
          check_value("query_ready", 1'b0, query_ready);
          check_value("pos_bias_ready", 1'b0, pos_bias_ready);
        end
        // Key rows that transferred on this edge
        if (key_valid && key_ready) begin
          keys_seen++;
        end
      end while (!query_ready);
      check_value("pos_bias_ready", 1'b1, pos_bias_ready);
    end
    query_valid    <= 1'b0;
    pos_bias_valid <= 1'b0;
  endtask

  // Rows must come out once each and in query order
  task automatic collect_out_rows(input int head, input bit throttle);
    int base;
    base = head * HEAD_WORDS + E_OFS;
    for (int r = 0; r < SEQ_LEN; r++) begin
      do begin
        out_ready <= throttle ? (($urandom % 4) != 0) : 1'b1;
        @(posedge clk);
      end while (!(out_valid && out_ready));
      for (int d = 0; d < HEAD_DIM; d++) begin
        check_value($sformatf("out[%0d] head %0d row %0d", d, head, r),
                    stim_mem[base + r * HEAD_DIM + d], out[d]);
      end
    end
    out_ready <= 1'b0;
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    error_count++;
    $display("timeout: the output rows did not all arrive within %0d cycles", TIMEOUT_LIMIT);
    $display("%0d checks, %0d errors", check_count, error_count);
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h943024a3));
    clk            = 1'b0;
    arst_n         = 1'b0;
    query          = '{default: '0};
    query_valid    = 1'b0;
    key            = '{default: '0};
    key_valid      = 1'b0;
    value          = '{default: '0};
    value_valid    = 1'b0;
    pos_bias       = '{default: '0};
    pos_bias_valid = 1'b0;
    out_ready      = 1'b0;
    error_count    = 0;
    check_count    = 0;
    $readmemh("sim/attn_stimulus.txt", stim_mem);

    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // State right after reset
    check_value("out_valid", 1'b0, out_valid);
    check_value("key_ready", 1'b1, key_ready);
    check_value("value_ready", 1'b1, value_ready);
    check_value("query_ready", 1'b0, query_ready);
    check_value("pos_bias_ready", 1'b0, pos_bias_ready);

    if ($isunknown(stim_mem[NUM_WORDS-1])) begin
      error_count++;
      $display("stimulus file sim/attn_stimulus.txt is missing or holds too few words");
    end else begin
      for (int h = 0; h < NUM_HEADS; h++) begin
        fork
          load_key_rows(h);
          load_value_rows(h);
          offer_query_rows(h);
          collect_out_rows(h, h > 0);
        join
        @(posedge clk);
        // Both buffers free again and nothing left in the output stage
        check_value("key_ready", 1'b1, key_ready);
        check_value("value_ready", 1'b1, value_ready);
        check_value("out_valid", 1'b0, out_valid);
      end
    end

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hw/attn_pkg.sv
hw/operand_buffer.sv
hw/score_unit.sv
hw/weighted_sum_unit.sv
hw/attention_head.sv
sim/tb_attention_head.sv
